// ==== s2m_pkg.sv ====
/* stream-to-memory shared definitions
   widths, constants, engine state codes and record formats */
`default_nettype none

package s2m_pkg;

  // stream beat
  localparam int DATA_W     = 32;
  localparam int KEEP_W     = 4;
  localparam int BEAT_BYTES = 4;

  // memory side
  localparam int ADDR_W = 32;
  localparam int LEN_W  = 8;    // beat counts, fifo occupancy
  localparam logic [ADDR_W-1:0] BASE_ADDR   = 32'h0000_1000;
  localparam logic [LEN_W-1:0]  BURST_BEATS = 8'd16;   // 64-byte window

  // buffering
  localparam int DATA_DEPTH = 64;
  localparam int REC_DEPTH  = 8;

  // record fields
  localparam int FDSTI_W = 28;
  localparam int STI_W   = 8;
  localparam int SSI_W   = 8;
  localparam int BLK_W   = 16;

  // burst engine states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;
  localparam logic [1:0] ST_RESP = 2'd3;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;    // end of block
  } beat_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;     // beats minus one
  } aw_cmd_t;

  typedef struct packed {
    logic [FDSTI_W-1:0] fdsti;
    logic [ADDR_W-1:0]  s_addr;
    logic [ADDR_W-1:0]  e_addr;  // last byte of frame
  } addr_rec_t;

  typedef struct packed {
    logic [FDSTI_W-1:0] fdsti;
    logic [SSI_W-1:0]   ssi;
    logic [STI_W-1:0]   sti;
    logic [BLK_W-1:0]   blk_cnt;
  } info_rec_t;

endpackage

`default_nettype wire

// ==== sync_fifo.sv ====
/* synchronous fifo, first-word fall-through
   circular buffer with occupancy count, DEPTH a power of two */
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [WIDTH-1:0]          in_data,
  input  logic                      in_valid,
  output logic                      in_ready,
  output logic [WIDTH-1:0]          out_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [s2m_pkg::LEN_W-1:0] count
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     push;
  logic                     pop;

  assign in_ready  = (count != DEPTH[s2m_pkg::LEN_W-1:0]);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];   // head word shown directly

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== frame_tracker.sv ====
/* frame tracker
   counts beats per block and bytes per frame, emits address and info records */
`default_nettype none

module frame_tracker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        beat_fire,
  input  logic                        beat_last,
  input  logic                        frame_ack,
  input  logic                        fi_valid,
  input  logic                        bi_valid,
  input  logic [s2m_pkg::FDSTI_W-1:0] fdsti,
  input  logic [s2m_pkg::STI_W-1:0]   sti,
  input  logic [s2m_pkg::SSI_W-1:0]   ssi,
  output s2m_pkg::addr_rec_t          addr_rec,
  output logic                        addr_rec_valid,
  output s2m_pkg::info_rec_t          info_rec,
  output logic                        info_rec_valid
);

  logic [s2m_pkg::BLK_W-1:0]  blk_cnt;      // beats so far in block
  logic [s2m_pkg::ADDR_W-1:0] frame_bytes;  // bytes so far in frame
  logic [s2m_pkg::ADDR_W-1:0] frame_start;
  logic                       blk_end;

  assign blk_end = beat_fire & beat_last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      blk_cnt <= '0;
    end else if (beat_fire) begin
      if (beat_last) begin
        blk_cnt <= '0;
      end else begin
        blk_cnt <= blk_cnt + 1'b1;
      end
    end
  end

  // tkeep ignored as every beat is a full word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_bytes <= '0;
      frame_start <= s2m_pkg::BASE_ADDR;
    end else if (frame_ack) begin
      frame_start <= frame_start + frame_bytes;
      // a beat in the ack cycle opens the next frame
      frame_bytes <= beat_fire ? s2m_pkg::BEAT_BYTES : '0;
    end else if (beat_fire) begin
      frame_bytes <= frame_bytes + s2m_pkg::BEAT_BYTES;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      addr_rec_valid <= 1'b0;
      info_rec_valid <= 1'b0;
    end else begin
      addr_rec_valid <= frame_ack & fi_valid;         // one-cycle push
      info_rec_valid <= blk_end & fi_valid & bi_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_ack) begin
      addr_rec.fdsti  <= fdsti;
      addr_rec.s_addr <= frame_start;
      addr_rec.e_addr <= frame_start + frame_bytes - 1'b1;
    end
    if (blk_end) begin
      info_rec.fdsti   <= fdsti;
      info_rec.ssi     <= ssi;
      info_rec.sti     <= sti;
      info_rec.blk_cnt <= blk_cnt + 1'b1;  // include the last beat
    end
  end

endmodule

`default_nettype wire

// ==== burst_engine.sv ====
/* burst engine
   issues AXI4 write bursts from the data fifo without crossing 64-byte windows */
`default_nettype none

module burst_engine (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        tlast_in,
  input  s2m_pkg::beat_t              fifo_beat,
  input  logic                        fifo_valid,
  input  logic [s2m_pkg::LEN_W-1:0]   fifo_count,
  output logic                        fifo_pop,
  output s2m_pkg::aw_cmd_t            aw,
  output logic                        awvalid,
  input  logic                        awready,
  output logic [s2m_pkg::DATA_W-1:0]  wdata,
  output logic [s2m_pkg::KEEP_W-1:0]  wstrb,
  output logic                        wlast,
  output logic                        wvalid,
  input  logic                        wready,
  input  logic                        bvalid,
  output logic                        bready
);

  logic [1:0]                 state;
  logic [s2m_pkg::LEN_W-1:0]  tlast_cnt;   // block ends waiting in fifo
  logic [s2m_pkg::ADDR_W-1:0] wr_addr;
  logic [s2m_pkg::LEN_W-1:0]  win_used;    // beats used in current window
  logic [s2m_pkg::LEN_W-1:0]  beats_left;  // W beats after the current one
  logic [s2m_pkg::LEN_W-1:0]  room;
  logic [s2m_pkg::LEN_W-1:0]  burst_beats;
  logic [s2m_pkg::LEN_W-1:0]  win_next;
  logic [s2m_pkg::ADDR_W-1:0] burst_bytes;
  logic                       issue;
  logic                       tlast_out;

  assign room        = s2m_pkg::BURST_BEATS - win_used;
  assign burst_beats = aw.len + 1'b1;
  assign win_next    = win_used + burst_beats;
  assign burst_bytes = {{(s2m_pkg::ADDR_W - s2m_pkg::LEN_W){1'b0}}, burst_beats}
                       * s2m_pkg::BEAT_BYTES;

  // full window available, or a block end must be flushed
  assign issue = (fifo_count >= room) || ((tlast_cnt != '0) && (fifo_count != '0));

  assign awvalid  = (state == s2m_pkg::ST_ADDR);
  assign wvalid   = (state == s2m_pkg::ST_DATA) & fifo_valid;
  assign wlast    = (state == s2m_pkg::ST_DATA) & (beats_left == '0);
  assign wdata    = fifo_beat.data;
  assign wstrb    = fifo_beat.keep;
  assign bready   = (state == s2m_pkg::ST_RESP);
  assign fifo_pop = wvalid & wready;

  assign tlast_out = fifo_pop & fifo_beat.last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tlast_cnt <= '0;
    end else if (tlast_in && !tlast_out) begin
      tlast_cnt <= tlast_cnt + 1'b1;
    end else if (tlast_out && !tlast_in) begin
      tlast_cnt <= tlast_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= s2m_pkg::ST_IDLE;
      wr_addr    <= s2m_pkg::BASE_ADDR;
      win_used   <= '0;
      beats_left <= '0;
      aw.addr    <= s2m_pkg::BASE_ADDR;
      aw.len     <= '0;
    end else begin
      case (state)
        s2m_pkg::ST_IDLE: begin
          if (issue) begin
            aw.addr <= wr_addr;
            aw.len  <= ((fifo_count < room) ? fifo_count : room) - 1'b1;
            state   <= s2m_pkg::ST_ADDR;
          end
        end
        s2m_pkg::ST_ADDR: begin
          if (awready) begin
            wr_addr    <= wr_addr + burst_bytes;
            win_used   <= (win_next == s2m_pkg::BURST_BEATS) ? '0 : win_next;
            beats_left <= aw.len;
            state      <= s2m_pkg::ST_DATA;
          end
        end
        s2m_pkg::ST_DATA: begin
          if (fifo_pop) begin
            if (beats_left == '0) begin
              state <= s2m_pkg::ST_RESP;
            end else begin
              beats_left <= beats_left - 1'b1;
            end
          end
        end
        default: begin
          if (bvalid) state <= s2m_pkg::ST_IDLE;   // response ends burst
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== stream_to_mem.sv ====
/* stream-to-memory write master
   buffers stream beats, writes them over AXI4 and queues frame and block records */
`default_nettype none

module stream_to_mem (
  input  logic                        clk,
  input  logic                        rst,
  // stream in
  input  s2m_pkg::beat_t              s_beat,
  input  logic                        s_valid,
  output logic                        s_ready,
  input  logic                        frame_valid,
  input  logic                        frame_last,
  input  logic                        fi_valid,
  input  logic                        bi_valid,
  input  logic [s2m_pkg::FDSTI_W-1:0] fdsti,
  input  logic [s2m_pkg::STI_W-1:0]   sti,
  input  logic [s2m_pkg::SSI_W-1:0]   ssi,
  output logic                        frame_ack,
  // AXI4 write
  output logic [s2m_pkg::ADDR_W-1:0]  awaddr,
  output logic [s2m_pkg::LEN_W-1:0]   awlen,
  output logic                        awvalid,
  input  logic                        awready,
  output logic [s2m_pkg::DATA_W-1:0]  wdata,
  output logic [s2m_pkg::KEEP_W-1:0]  wstrb,
  output logic                        wlast,
  output logic                        wvalid,
  input  logic                        wready,
  input  logic                        bvalid,
  output logic                        bready,
  // records
  output s2m_pkg::addr_rec_t          m_addr,
  output logic                        m_addr_valid,
  input  logic                        m_addr_ready,
  output s2m_pkg::info_rec_t          m_info,
  output logic                        m_info_valid,
  input  logic                        m_info_ready
);

  s2m_pkg::beat_t            fifo_beat;
  logic                      fifo_valid;
  logic                      fifo_pop;
  logic [s2m_pkg::LEN_W-1:0] fifo_count;
  logic                      in_valid;
  logic                      beat_fire;
  logic                      tlast_in;
  s2m_pkg::aw_cmd_t          aw;
  s2m_pkg::addr_rec_t        addr_rec;
  logic                      addr_rec_valid;
  s2m_pkg::info_rec_t        info_rec;
  logic                      info_rec_valid;

  assign in_valid  = s_valid & frame_valid;   // beats only count inside a frame
  assign beat_fire = in_valid & s_ready;
  assign tlast_in  = beat_fire & s_beat.last;
  assign frame_ack = frame_valid & frame_last;

  assign awaddr = aw.addr;
  assign awlen  = aw.len;

  sync_fifo #(
    .WIDTH ($bits(s2m_pkg::beat_t)),
    .DEPTH (s2m_pkg::DATA_DEPTH)
  ) i_data_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (s_beat),
    .in_valid  (in_valid),
    .in_ready  (s_ready),
    .out_data  (fifo_beat),
    .out_valid (fifo_valid),
    .out_ready (fifo_pop),
    .count     (fifo_count)
  );

  frame_tracker i_frame_tracker (
    .clk            (clk),
    .rst            (rst),
    .beat_fire      (beat_fire),
    .beat_last      (s_beat.last),
    .frame_ack      (frame_ack),
    .fi_valid       (fi_valid),
    .bi_valid       (bi_valid),
    .fdsti          (fdsti),
    .sti            (sti),
    .ssi            (ssi),
    .addr_rec       (addr_rec),
    .addr_rec_valid (addr_rec_valid),
    .info_rec       (info_rec),
    .info_rec_valid (info_rec_valid)
  );

  // a push into a full record queue is lost
  sync_fifo #(
    .WIDTH ($bits(s2m_pkg::addr_rec_t)),
    .DEPTH (s2m_pkg::REC_DEPTH)
  ) i_addr_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (addr_rec),
    .in_valid  (addr_rec_valid),
    .in_ready  (),
    .out_data  (m_addr),
    .out_valid (m_addr_valid),
    .out_ready (m_addr_ready),
    .count     ()
  );

  sync_fifo #(
    .WIDTH ($bits(s2m_pkg::info_rec_t)),
    .DEPTH (s2m_pkg::REC_DEPTH)
  ) i_info_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (info_rec),
    .in_valid  (info_rec_valid),
    .in_ready  (),
    .out_data  (m_info),
    .out_valid (m_info_valid),
    .out_ready (m_info_ready),
    .count     ()
  );

  burst_engine i_burst_engine (
    .clk        (clk),
    .rst        (rst),
    .tlast_in   (tlast_in),
    .fifo_beat  (fifo_beat),
    .fifo_valid (fifo_valid),
    .fifo_count (fifo_count),
    .fifo_pop   (fifo_pop),
    .aw         (aw),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

endmodule

`default_nettype wire

// ==== tb_stream_to_mem.sv ====
/* testbench for the stream-to-memory write master
   drives framed stream data, models the AXI slave, checks memory and records */
`default_nettype none

module tb_stream_to_mem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 100;
  localparam int BEAT_BUDGET = 32 + 25 + 26 + 14 + 94;   // beats and idle cycles per test

  logic                        clk = 1'b0;
  logic                        rst;
  s2m_pkg::beat_t              s_beat;
  logic                        s_valid;
  logic                        s_ready;
  logic                        frame_valid;
  logic                        frame_last;
  logic                        frame_ack;
  logic                        fi_valid;
  logic                        bi_valid;
  logic [s2m_pkg::FDSTI_W-1:0] fdsti;
  logic [s2m_pkg::STI_W-1:0]   sti;
  logic [s2m_pkg::SSI_W-1:0]   ssi;
  logic [s2m_pkg::ADDR_W-1:0]  awaddr;
  logic [s2m_pkg::LEN_W-1:0]   awlen;
  logic [s2m_pkg::DATA_W-1:0]  wdata;
  logic [s2m_pkg::KEEP_W-1:0]  wstrb;
  logic                        awvalid;
  logic                        awready;
  logic                        wlast;
  logic                        wvalid;
  logic                        wready;
  logic                        bvalid;
  logic                        bready;
  s2m_pkg::addr_rec_t          m_addr;
  s2m_pkg::info_rec_t          m_info;
  logic                        m_addr_valid;
  logic                        m_addr_ready;
  logic                        m_info_valid;
  logic                        m_info_ready;

  integer                      seed = 32'hc972d2ba;
  string                       test_name = "reset";
  int                          errors = 0;
  logic                        stall = 1'b0;          // random awready and wready
  logic [31:0]                 exp_data[$];
  logic [s2m_pkg::KEEP_W-1:0]  exp_keep[$];
  s2m_pkg::addr_rec_t          exp_addr[$];
  s2m_pkg::info_rec_t          exp_info[$];
  logic [31:0]                 mem[logic [31:0]];
  s2m_pkg::aw_cmd_t            bursts[$];
  logic [31:0]                 frame_base = s2m_pkg::BASE_ADDR;
  logic [31:0]                 next_addr = s2m_pkg::BASE_ADDR;
  logic [31:0]                 w_addr = '0;
  logic [31:0]                 last_byte;
  int                          w_left = 0;
  int                          words_done = 0;
  int                          mem_checked = 0;
  logic                        aw_busy = 1'b0;
  logic                        resp_pending = 1'b0;

  stream_to_mem i_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string why);
    errors++;
    $display("%s: %s", test_name, why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare(input string what, input logic [127:0] exp_v,
                         input logic [127:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("Mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // slave readies and response with varying latency
  always @(negedge clk) begin
    awready = !stall || ($random(seed) % 4 != 0);
    wready  = !stall || ($random(seed) % 3 != 0);
    if (!bvalid) bvalid = resp_pending && ($random(seed) % 2 == 0);
    else if (!resp_pending) bvalid = 1'b0;
  end

  always @(posedge clk) begin
    if (awvalid && awready) begin
      if (aw_busy) fail_run("a second burst was issued before the write response");
      last_byte = awaddr + {22'd0, awlen, 2'b11};
      compare("burst address", 128'(next_addr), 128'(awaddr));
      compare("64-byte window", 128'(awaddr[31:6]), 128'(last_byte[31:6]));
      bursts.push_back({awaddr, awlen});
      next_addr = awaddr + {22'd0, awlen + 8'd1, 2'b00};
      w_addr = awaddr;
      w_left = int'(awlen) + 1;
      aw_busy = 1'b1;
    end
    if (wvalid && wready) begin
      if (!aw_busy || w_left == 0) fail_run("a write beat arrived outside any burst");
      mem[w_addr] = wdata;
      w_addr = w_addr + 32'd4;
      w_left = w_left - 1;
      compare("wlast", 128'(w_left == 0), 128'(wlast));
      compare("wstrb", 128'(exp_keep[words_done]), 128'(wstrb));
      words_done++;
      if (w_left == 0) resp_pending = 1'b1;
    end
    if (bvalid && bready) begin
      resp_pending = 1'b0;
      aw_busy = 1'b0;
    end
  end

  // record sinks in expected order
  always @(posedge clk) begin
    if (m_addr_valid && m_addr_ready) begin
      if (exp_addr.size() == 0) fail_run("a frame address record appeared unexpectedly");
      compare("frame address record", 128'(exp_addr[0]), 128'(m_addr));
      exp_addr.delete(0);
    end
    if (m_info_valid && m_info_ready) begin
      if (exp_info.size() == 0) fail_run("a block info record appeared unexpectedly");
      compare("block info record", 128'(exp_info[0]), 128'(m_info));
      exp_info.delete(0);
    end
  end

  task automatic send_block(input int len, input logic bi, input logic [7:0] idx);
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      if (i == 0) ssi = 8'($random(seed));
      s_beat.data = $random(seed);
      s_beat.keep = 4'($random(seed));
      s_beat.last = (i == len - 1);
      s_valid     = 1'b1;
      bi_valid    = bi;
      sti         = idx;
      while (!s_ready) @(negedge clk);   // taken on the next rising edge
      exp_data.push_back(s_beat.data);
      exp_keep.push_back(s_beat.keep);
    end
    if (fi_valid && bi) exp_info.push_back({fdsti, ssi, idx, 16'(len)});
  endtask

  task automatic send_frame(input logic [27:0] fd, input logic fi, input int n0,
                            input int n1, input int n2, input logic [2:0] bi);
    int beats;
    beats = n0 + n1 + n2;
    @(negedge clk);
    frame_valid = 1'b1;
    fi_valid    = fi;
    fdsti       = fd;
    send_block(n0, bi[0], 8'd0);
    if (n1 > 0) send_block(n1, bi[1], 8'd1);
    if (n2 > 0) send_block(n2, bi[2], 8'd2);
    @(negedge clk);
    compare("frame_ack before frame_last", 128'(1'b0), 128'(frame_ack));
    s_valid    = 1'b0;
    frame_last = 1'b1;
    if (fi) exp_addr.push_back({fd, frame_base, frame_base + 32'(4 * beats) - 32'd1});
    frame_base = frame_base + 32'(4 * beats);
    @(negedge clk);
    compare("frame_ack", 128'(1'b1), 128'(frame_ack));
    frame_last  = 1'b0;
    frame_valid = 1'b0;
  endtask

  // wait for memory writes and records, then compare memory
  task automatic finish_test();
    int          beats;
    logic [31:0] addr;
    while (words_done < exp_data.size() || aw_busy || exp_addr.size() != 0
           || exp_info.size() != 0) @(negedge clk);
    for (int i = mem_checked; i < exp_data.size(); i++) begin
      addr = s2m_pkg::BASE_ADDR + 32'(4 * i);
      if (!mem.exists(addr)) fail_run("a stream word was never written to memory");
      compare("memory word", 128'(exp_data[i]), 128'(mem[addr]));
    end
    mem_checked = exp_data.size();
    beats = 0;
    foreach (bursts[i]) beats += int'(bursts[i].len) + 1;
    compare("beats in bursts", 128'(exp_data.size()), 128'(beats));
  endtask

  task automatic single_block_test();
    test_name = "single_block";
    send_frame(28'h0000011, 1'b1, 32, 0, 0, 3'b001);
    finish_test();
  endtask

  task automatic two_frames_test();
    test_name = "two_frames";
    send_frame(28'h0000021, 1'b1, 5, 0, 0, 3'b001);
    send_frame(28'h0000022, 1'b1, 20, 0, 0, 3'b001);
    finish_test();
  endtask

  task automatic frame_records_test();
    test_name = "frame_records";
    send_frame(28'h0000031, 1'b1, 8, 0, 0, 3'b001);
    send_frame(28'h0000032, 1'b0, 12, 0, 0, 3'b001);   // no record expected
    send_frame(28'h0000033, 1'b1, 6, 0, 0, 3'b001);
    finish_test();
  endtask

  task automatic block_records_test();
    test_name = "block_records";
    send_frame(28'h0000041, 1'b1, 4, 7, 3, 3'b101);
    finish_test();
  endtask

  task automatic backpressure_test();
    test_name = "backpressure";
    stall = 1'b1;
    m_addr_ready = 1'b0;
    m_info_ready = 1'b0;
    send_frame(28'h00000a1, 1'b1, 9, 14, 0, 3'b011);
    send_frame(28'h00000a2, 1'b1, 3, 0, 0, 3'b001);
    send_frame(28'h00000a3, 1'b0, 17, 0, 0, 3'b001);
    send_frame(28'h00000a4, 1'b1, 6, 5, 0, 3'b011);
    repeat (40) @(negedge clk);
    m_addr_ready = 1'b1;
    m_info_ready = 1'b1;
    finish_test();
    stall = 1'b0;
  endtask

  initial begin
    #(BEAT_BUDGET * 20 * CLK_PERIOD);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin
    rst          = 1'b1;
    s_beat       = '0;
    s_valid      = 1'b0;
    frame_valid  = 1'b0;
    frame_last   = 1'b0;
    fi_valid     = 1'b0;
    bi_valid     = 1'b0;
    fdsti        = '0;
    sti          = '0;
    ssi          = '0;
    awready      = 1'b0;
    wready       = 1'b0;
    bvalid       = 1'b0;
    m_addr_ready = 1'b1;
    m_info_ready = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    single_block_test();
    two_frames_test();
    frame_records_test();
    block_records_test();
    backpressure_test();
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== stream_to_mem.f ====
s2m_pkg.sv
sync_fifo.sv
frame_tracker.sv
burst_engine.sv
stream_to_mem.sv
tb_stream_to_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stream_to_mem testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f stream_to_mem.f \
  --top-module tb_stream_to_mem -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log
if grep -q "Simulation failed" sim.log || ! grep -q "Simulation completed successfully" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
